// ==== build.sh ====
#!/usr/bin/env bash
# compile and run the link framer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f link_framer.f \
  --top-module link_framer_tb \
  -o link_framer_sim

if ! sim_out=$(./obj_dir/link_framer_sim); then
  echo "$sim_out"
  echo "simulation exited with an error"
  exit 1
fi
echo "$sim_out"

if grep -q "All checks passed" <<< "$sim_out"; then
  exit 0
fi
exit 1

// ==== link_framer.f ====
verilog/framing_pkg.sv
verilog/byte_stream_if.sv
verilog/packet_dispatcher.sv
verilog/escaper.sv
verilog/frame_encoder.sv
verilog/frame_merger.sv
verilog/link_framer_top.sv
tb/link_framer_tb.sv

// ==== tb/link_framer_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the link framer, run as the simulation top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module link_framer_tb;

  // link byte values, kept apart from the design package
  localparam logic [7:0] start_code  = 8'h7D;
  localparam logic [7:0] stop_code   = 8'h7E;
  localparam logic [7:0] escape_code = 8'h7F;
  // random test is about 1300 beats at half ready, so far below this
  localparam int max_cycles = 20000;

  logic       aclk = 1'b0;
  logic       aresetn;
  logic       in_tvalid;
  logic       in_tready;
  logic [7:0] in_tdata;
  logic       in_tlast;
  logic       out_tvalid;
  logic       out_tready;
  logic [7:0] out_tdata;
  logic       out_tlast;

  // packet under construction, then flat stimulus and lengths
  logic [7:0]  pkt_buf [$];
  logic [7:0]  stim_q [$];
  int          len_q [$];
  // expected beats as {tlast, tdata}
  logic [8:0]  exp_q [$];
  int          errors = 0;
  int          beats_seen = 0;
  int          cycle_count = 0;
  logic        random_ready = 1'b0;
  logic        gaps_on = 1'b0;
  logic [31:0] data_rng = 32'd68786;
  logic [31:0] ready_rng;

  link_framer_top dut (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .in_tvalid  (in_tvalid),
    .in_tready  (in_tready),
    .in_tdata   (in_tdata),
    .in_tlast   (in_tlast),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready),
    .out_tdata  (out_tdata),
    .out_tlast  (out_tlast)
  );

  // 8 ns period
  always #4 aclk = ~aclk;

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // stimulus stream, separate from the ready stream
  function automatic logic [31:0] next_rand();
    data_rng = xorshift(data_rng);
    return data_rng;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  // reference frame: START, stuffed bytes, STOP with tlast
  task automatic queue_packet();
    exp_q.push_back({1'b0, start_code});
    foreach (pkt_buf[i]) begin
      stim_q.push_back(pkt_buf[i]);
      if (pkt_buf[i] == start_code || pkt_buf[i] == stop_code || pkt_buf[i] == escape_code) begin
        exp_q.push_back({1'b0, escape_code});
      end
      exp_q.push_back({1'b0, pkt_buf[i]});
    end
    exp_q.push_back({1'b1, stop_code});
    len_q.push_back(pkt_buf.size());
    pkt_buf.delete();
  endtask

  // called 1 ns after an edge, returns the same way
  task automatic drive_all();
    logic [31:0] r;
    int          len;
    while (len_q.size() != 0) begin
      len = len_q.pop_front();
      for (int j = 0; j < len; j++) begin
        // idle gap only before tvalid goes up
        if (gaps_on) begin
          r = next_rand();
          if (r[1:0] == 2'd0) begin
            in_tvalid = 1'b0;
            @(posedge aclk);
            #1;
          end
        end
        in_tvalid = 1'b1;
        in_tdata  = stim_q.pop_front();
        in_tlast  = (j == len - 1);
        @(posedge aclk);
        while (!in_tready) begin
          @(posedge aclk);
        end
        #1;
      end
    end
    in_tvalid = 1'b0;
    in_tlast  = 1'b0;
  endtask

  task automatic collect_all();
    logic [8:0] beat;
    while (exp_q.size() != 0) begin
      @(posedge aclk);
      if (out_tvalid && out_tready) begin
        beat = exp_q.pop_front();
        beats_seen++;
        check_value("out_tdata", 32'(out_tdata), 32'(beat[7:0]));
        check_value("out_tlast", 32'(out_tlast), 32'(beat[8]));
        // tlast only ever on STOP, never on an ESCAPE
        if (out_tlast) begin
          check_value("out_tdata with out_tlast", 32'(out_tdata), 32'(stop_code));
        end
      end
    end
    // nothing may follow the last frame
    repeat (8) begin
      @(posedge aclk);
      if (out_tvalid) begin
        errors++;
        $display("extra output beat %h after the last expected frame", out_tdata);
      end
    end
  endtask

  task automatic run_traffic();
    fork
      drive_all();
      collect_all();
    join
    #1;
  endtask

  task automatic idle_after_reset();
    repeat (10) begin
      @(posedge aclk);
      check_value("out_tvalid", 32'(out_tvalid), 32'd0);
      check_value("in_tready", 32'(in_tready), 32'd1);
    end
    #1;
  endtask

  task automatic plain_packet();
    for (int k = 0; k < 12; k++) begin
      pkt_buf.push_back(8'h10 + 8'(k * 7));
    end
    queue_packet();
    run_traffic();
  endtask

  // reserved bytes at the edges and inside
  task automatic reserved_bytes();
    pkt_buf = '{8'h7D, 8'h01, 8'h7E, 8'h7F, 8'h02, 8'h7E};
    queue_packet();
    pkt_buf = '{8'h7F, 8'h33, 8'h7D, 8'h7F};
    queue_packet();
    pkt_buf = '{8'h7E};
    queue_packet();
    run_traffic();
  endtask

  task automatic ordered_packets();
    int lens [8] = '{3, 1, 7, 2, 12, 5, 1, 9};
    logic [7:0] singles [4] = '{8'h7E, 8'h00, 8'h7D, 8'hA5};
    foreach (singles[s]) begin
      pkt_buf.push_back(singles[s]);
      queue_packet();
    end
    foreach (lens[n]) begin
      for (int k = 0; k < lens[n]; k++) begin
        pkt_buf.push_back(8'(n * 31 + k * 13));
      end
      queue_packet();
    end
    run_traffic();
  endtask

  task automatic random_packets();
    logic [31:0] r;
    int          len;
    random_ready = 1'b1;
    gaps_on      = 1'b1;
    repeat (50) begin
      len = 1 + int'(next_rand() % 32'd40);
      repeat (len) begin
        r = next_rand();
        // one byte in eight is reserved
        if (r[10:8] == 3'd0) begin
          pkt_buf.push_back(start_code + 8'(r % 32'd3));
        end else begin
          pkt_buf.push_back(r[7:0]);
        end
      end
      queue_packet();
    end
    run_traffic();
    random_ready = 1'b0;
    gaps_on      = 1'b0;
  endtask

  // output back-pressure, 1 ns after each edge
  initial begin : ready_gen
    out_tready = 1'b0;
    ready_rng  = xorshift(32'd68786);
    forever begin
      @(posedge aclk);
      #1;
      if (random_ready) begin
        ready_rng  = xorshift(ready_rng);
        out_tready = ready_rng[5];
      end else begin
        out_tready = 1'b1;
      end
    end
  end

  initial begin : watchdog
    wait (cycle_count >= max_cycles);
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("Checks failed");
    $finish;
  end

  initial begin : main
    aresetn   = 1'b0;
    in_tvalid = 1'b0;
    in_tdata  = 8'h00;
    in_tlast  = 1'b0;
    repeat (4) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    idle_after_reset();
    plain_packet();
    reserved_bytes();
    ordered_packets();
    random_packets();

    $display("errors: %0d, output beats checked: %0d", errors, beats_seen);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/byte_stream_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one AXI4-Stream byte channel with tlast
// connect the producer to source and the consumer to sink
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;

  // beat moves when tvalid and tready are both high
  logic       tvalid;
  logic       tready;
  logic [7:0] tdata;
  // marks the last byte of a packet or frame
  logic       tlast;

  // producer side
  modport source (
    output tvalid,
    output tdata,
    output tlast,
    input  tready
  );

  // consumer side
  modport sink (
    input  tvalid,
    input  tdata,
    input  tlast,
    output tready
  );

endinterface

`default_nettype wire

// ==== verilog/escaper.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// puts an ESCAPE byte in front of every START, STOP or ESCAPE byte
// combinational path, one flag register per lane
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module escaper
  import framing_pkg::*;
(
  input  logic          aclk,
  input  logic          aresetn,
  byte_stream_if.sink   target,
  byte_stream_if.source initiator
);

  logic reserved;
  // ESCAPE for the held byte already went out
  logic esc_sent;
  logic insert_valid;
  logic insert_xfer;
  logic data_xfer;
  logic out_xfer;
  // last output beat opened an escape pair, next one is literal
  logic out_esc;

  // bytes that need stuffing
  assign reserved = target.tdata inside {start_byte, stop_byte, escape_byte};

  // escape goes first, data byte waits
  assign insert_valid = target.tvalid && reserved && !esc_sent;
  assign insert_xfer  = insert_valid && initiator.tready;
  assign data_xfer    = target.tvalid && target.tready;
  assign out_xfer     = initiator.tvalid && initiator.tready;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      esc_sent <= 1'b0;
    end else if (insert_xfer) begin
      esc_sent <= 1'b1;
    end else if (data_xfer) begin
      esc_sent <= 1'b0;
    end
  end

  // mux toward the output, escape has priority
  assign initiator.tvalid = target.tvalid;
  assign initiator.tdata  = insert_valid ? escape_byte : target.tdata;
  assign initiator.tlast  = insert_valid ? 1'b0 : target.tlast;

  // input only sees ready once its escape is gone
  assign target.tready = insert_valid ? 1'b0 : initiator.tready;

  // decodes the output stream as the far end would
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      out_esc <= 1'b0;
    end else if (out_xfer) begin
      out_esc <= !out_esc && initiator.tdata == escape_byte;
    end
  end

  // an ESCAPE that opens a pair never closes a packet
  a_escape_no_last: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_xfer && !out_esc && initiator.tdata == escape_byte |-> !initiator.tlast
  );

  // every reserved input byte leaves right behind an ESCAPE
  a_escape_then_byte: assert property (
    @(posedge aclk) disable iff (!aresetn)
    data_xfer && reserved |-> out_esc
  );

endmodule

`default_nettype wire

// ==== verilog/frame_encoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one lane: START, escaped packet, STOP with tlast, into a small FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frame_encoder
  import framing_pkg::*;
(
  input  logic          aclk,
  input  logic          aresetn,
  byte_stream_if.sink   pkt,
  byte_stream_if.source frame
);

  // escaped packet bytes
  byte_stream_if esc_bus ();

  logic [1:0]            state;
  // first escaped byte, parked while START is written
  logic                  hold_valid;
  logic [7:0]            hold_data;
  logic                  hold_last;
  logic                  wr_valid;
  logic                  wr_en;
  logic [7:0]            wr_data;
  logic                  wr_last;
  logic                  body_last;
  logic                  full;
  logic                  rd_en;
  logic [8:0]            mem [lane_fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;

  escaper u_escaper (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .target    (pkt),
    .initiator (esc_bus)
  );

  // byte offered to the FIFO in each state
  always_comb begin
    wr_valid = 1'b0;
    wr_data  = stop_byte;
    wr_last  = 1'b0;
    case (state)
      st_start: begin
        // START only once the packet shows up
        wr_valid = esc_bus.tvalid;
        wr_data  = start_byte;
      end
      st_body: begin
        wr_valid = hold_valid || esc_bus.tvalid;
        wr_data  = hold_valid ? hold_data : esc_bus.tdata;
      end
      st_stop: begin
        wr_valid = 1'b1;
        wr_last  = 1'b1;
      end
      default: wr_valid = 1'b0;
    endcase
  end

  assign wr_en     = wr_valid && !full;
  assign body_last = hold_valid ? hold_last : esc_bus.tlast;

  // take escaped bytes in start, or in body once the parked byte is gone
  assign esc_bus.tready = !full && (state == st_start || (state == st_body && !hold_valid));

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state      <= st_start;
      hold_valid <= 1'b0;
    end else if (wr_en) begin
      case (state)
        st_start: begin
          state      <= st_body;
          hold_valid <= 1'b1;
        end
        st_body: begin
          hold_valid <= 1'b0;
          if (body_last) begin
            state <= st_stop;
          end
        end
        default: state <= st_start;
      endcase
    end
  end

  // byte accepted together with START
  always_ff @(posedge aclk) begin
    if (state == st_start && wr_en) begin
      hold_data <= esc_bus.tdata;
      hold_last <= esc_bus.tlast;
    end
  end

  // output FIFO, {tlast, tdata} per entry
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {wr_last, wr_data};
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {fifo_ptr_w'(0), wr_en} - {fifo_ptr_w'(0), rd_en};
    end
  end

  assign full         = (count == (fifo_ptr_w + 1)'(lane_fifo_depth));
  assign frame.tvalid = (count != '0);
  assign frame.tdata  = mem[rd_ptr][7:0];
  assign frame.tlast  = mem[rd_ptr][8];
  assign rd_en        = frame.tvalid && frame.tready;

  // no write onto the unread head entry of a full FIFO
  a_no_write_full: assert property (
    @(posedge aclk) disable iff (!aresetn)
    wr_en |-> (wr_ptr != rd_ptr) || (count == '0)
  );

  // head entry holds while the merger stalls this lane
  a_head_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    frame.tvalid && !frame.tready |=> frame.tvalid && $stable(frame.tdata)
      && $stable(frame.tlast)
  );

endmodule

`default_nettype wire

// ==== verilog/frame_merger.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// drains whole frames from the lanes in the dispatcher's order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frame_merger
  import framing_pkg::*;
(
  input  logic        aclk,
  input  logic        aresetn,
  byte_stream_if.sink lanes [num_lanes],
  output logic        out_tvalid,
  output logic [7:0]  out_tdata,
  output logic        out_tlast,
  input  logic        out_tready
);

  // follows the dispatcher pointer, one frame per lane
  logic [lane_idx_w-1:0] ptr;
  logic [num_lanes-1:0]  lane_valid;
  logic [num_lanes-1:0]  lane_last;
  logic [7:0]            lane_data [num_lanes];
  logic                  out_xfer;
  // a frame is partly sent
  logic                  in_frame;

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    assign lane_valid[i] = lanes[i].tvalid;
    assign lane_data[i]  = lanes[i].tdata;
    assign lane_last[i]  = lanes[i].tlast;
    // unselected lanes are held off
    assign lanes[i].tready = out_tready && (ptr == lane_idx_w'(i));
  end

  assign out_tvalid = lane_valid[ptr];
  assign out_tdata  = lane_data[ptr];
  assign out_tlast  = lane_last[ptr];
  assign out_xfer   = out_tvalid && out_tready;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ptr      <= '0;
      in_frame <= 1'b0;
    end else if (out_xfer) begin
      in_frame <= !out_tlast;
      // next lane after the STOP byte
      if (out_tlast) begin
        if (ptr == lane_idx_w'(num_lanes - 1)) begin
          ptr <= '0;
        end else begin
          ptr <= ptr + 1'b1;
        end
      end
    end
  end

  // every frame on the link opens with START
  a_frame_starts: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_tvalid && !in_frame |-> out_tdata == start_byte
  );

  // output beat held under back-pressure
  a_out_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(out_tlast)
  );

endmodule

`default_nettype wire

// ==== verilog/framing_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants of the byte-stuffing link framer
// imported by wildcard in each module header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package framing_pkg;

  // reserved byte values on the link
  localparam logic [7:0] start_byte  = 8'h7D;
  localparam logic [7:0] stop_byte   = 8'h7E;
  localparam logic [7:0] escape_byte = 8'h7F;

  // lane fan-out, power of two
  localparam int num_lanes  = 4;
  localparam int lane_idx_w = $clog2(num_lanes);

  // per-lane output FIFO
  localparam int lane_fifo_depth = 16;
  localparam int fifo_ptr_w      = $clog2(lane_fifo_depth);

  // encoder sequencer states
  localparam logic [1:0] st_start = 2'd0;
  localparam logic [1:0] st_body  = 2'd1;
  localparam logic [1:0] st_stop  = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/link_framer_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link framer top: dispatcher, encoder lanes and merger, plain pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module link_framer_top
  import framing_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  // packet input
  input  logic       in_tvalid,
  output logic       in_tready,
  input  logic [7:0] in_tdata,
  input  logic       in_tlast,
  // framed output
  output logic       out_tvalid,
  input  logic       out_tready,
  output logic [7:0] out_tdata,
  output logic       out_tlast
);

  byte_stream_if in_bus ();
  // dispatcher to encoders
  byte_stream_if lane_bus [num_lanes] ();
  // encoders to merger
  byte_stream_if frame_bus [num_lanes] ();

  // input pins onto the bus
  assign in_bus.tvalid = in_tvalid;
  assign in_bus.tdata  = in_tdata;
  assign in_bus.tlast  = in_tlast;
  assign in_tready     = in_bus.tready;

  packet_dispatcher u_dispatcher (
    .aclk    (aclk),
    .aresetn (aresetn),
    .up      (in_bus),
    .lanes   (lane_bus)
  );

  for (genvar i = 0; i < num_lanes; i++) begin : g_enc
    frame_encoder u_encoder (
      .aclk    (aclk),
      .aresetn (aresetn),
      .pkt     (lane_bus[i]),
      .frame   (frame_bus[i])
    );
  end

  frame_merger u_merger (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .lanes      (frame_bus),
    .out_tvalid (out_tvalid),
    .out_tdata  (out_tdata),
    .out_tlast  (out_tlast),
    .out_tready (out_tready)
  );

endmodule

`default_nettype wire

// ==== verilog/packet_dispatcher.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hands whole input packets to the encoder lanes in round-robin order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module packet_dispatcher
  import framing_pkg::*;
(
  input  logic          aclk,
  input  logic          aresetn,
  byte_stream_if.sink   up,
  byte_stream_if.source lanes [num_lanes]
);

  // lane that owns the current packet
  logic [lane_idx_w-1:0] ptr;
  logic [num_lanes-1:0]  sel;
  logic [num_lanes-1:0]  lane_valid;
  logic [num_lanes-1:0]  lane_ready;
  logic                  last_xfer;
  // one-hot turn kept beside ptr, rotates once per packet
  logic [num_lanes-1:0]  turn;

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    assign sel[i] = (ptr == lane_idx_w'(i));
    // only the selected lane sees the beat
    assign lanes[i].tvalid = up.tvalid && sel[i];
    assign lanes[i].tdata  = up.tdata;
    assign lanes[i].tlast  = up.tlast;
    assign lane_valid[i]   = lanes[i].tvalid;
    assign lane_ready[i]   = lanes[i].tready;
  end

  // ready comes back from the selected lane only
  assign up.tready = lane_ready[ptr];

  assign last_xfer = up.tvalid && up.tready && up.tlast;

  // advance after the packet's last byte
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ptr  <= '0;
      turn <= num_lanes'(1);
    end else if (last_xfer) begin
      turn <= {turn[num_lanes-2:0], turn[num_lanes-1]};
      if (ptr == lane_idx_w'(num_lanes - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // no lane other than the one whose turn it is is offered a beat
  a_one_lane_valid: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (lane_valid & ~turn) == '0
  );

  // a stalled beat stays on the same lane until taken
  a_stall_same_lane: assert property (
    @(posedge aclk) disable iff (!aresetn)
    up.tvalid && !up.tready |=> up.tvalid && $stable(lane_valid)
  );

endmodule

`default_nettype wire
